// File: ar_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module ar_arbiter (
  input  wire logic                                          clk,
  input  wire logic                                          rstn,
  input  wire axi_pkg::ar_req_t [axi_pkg::num_masters-1:0]   m_ar,
  input  wire logic [axi_pkg::num_masters-1:0]               m_arvalid,
  output logic [axi_pkg::num_masters-1:0]                    m_arready,
  output axi_pkg::ar_sreq_t                                  g_ar,
  output logic                                               g_arvalid,
  input  wire logic                                          g_arready,
  input  wire logic [axi_pkg::num_masters-1:0]               m_done
);

  axi_pkg::arb_state_e state;
  axi_pkg::arb_state_e state_nxt;

  logic [axi_pkg::num_masters-1:0] m_lock;
  logic [axi_pkg::num_masters-1:0] elig;
  logic                            grant_idx;

  // A master with a read in flight does not compete
  assign elig = m_arvalid & ~m_lock;

  always_comb begin
    case (state)
      axi_pkg::arb_m0: grant_idx = 1'b0;
      axi_pkg::arb_m1: grant_idx = 1'b1;
      // Fixed priority, M0 first
      default: grant_idx = !elig[0];
    endcase
  end

  assign g_arvalid = elig[grant_idx];

  always_comb begin
    g_ar.id    = {grant_idx, m_ar[grant_idx].id};
    g_ar.addr  = m_ar[grant_idx].addr;
    g_ar.len   = m_ar[grant_idx].len;
    g_ar.size  = m_ar[grant_idx].size;
    g_ar.burst = m_ar[grant_idx].burst;
  end

  always_comb begin
    for (int m = 0; m < axi_pkg::num_masters; m++) begin
      m_arready[m] = (grant_idx == 1'(m)) && elig[m] && g_arready;
    end
  end

  // Grant is held while the request waits for the slave
  always_comb begin
    state_nxt = axi_pkg::arb_free;
    case (state)
      axi_pkg::arb_free: begin
        if (g_arvalid && !g_arready) begin
          state_nxt = grant_idx ? axi_pkg::arb_m1 : axi_pkg::arb_m0;
        end
      end
      axi_pkg::arb_m0, axi_pkg::arb_m1: begin
        if (g_arvalid && !g_arready) begin
          state_nxt = state;
        end
      end
      default: state_nxt = axi_pkg::arb_free;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= axi_pkg::arb_free;
    end else begin
      state <= state_nxt;
    end
  end

  // One outstanding read per master
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      m_lock <= '0;
    end else begin
      for (int m = 0; m < axi_pkg::num_masters; m++) begin
        if (m_done[m]) begin
          m_lock[m] <= 1'b0;
        end else if (m_arvalid[m] && m_arready[m]) begin
          m_lock[m] <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: ar_decoder.sv
`timescale 1ns/10ps
`default_nettype none

module ar_decoder (
  input  wire logic                                          clk,
  input  wire logic                                          rstn,
  input  wire axi_pkg::ar_sreq_t                             g_ar,
  input  wire logic                                          g_arvalid,
  output logic                                               g_arready,
  output axi_pkg::ar_sreq_t [axi_pkg::num_slaves-1:0]        s_ar,
  output logic [axi_pkg::num_slaves-1:0]                     s_arvalid,
  input  wire logic [axi_pkg::num_slaves-1:0]                s_arready,
  input  wire logic [axi_pkg::num_slaves-1:0]                s_done
);

  axi_pkg::slave_sel_t sel;
  logic [axi_pkg::num_slaves-1:0] s_lock;

  assign sel = axi_pkg::addr_decode(g_ar.addr);

  // Only the decoded slave sees the request
  always_comb begin
    for (int s = 0; s < axi_pkg::num_slaves; s++) begin
      if (sel[s]) begin
        s_ar[s] = g_ar;
      end else begin
        s_ar[s] = '0;
      end
      s_arvalid[s] = sel[s] && g_arvalid && !s_lock[s];
    end
  end

  // Busy slave looks not ready, so both sides agree on the handshake
  assign g_arready = |(sel & s_arready & ~s_lock);

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      s_lock <= '0;
    end else begin
      for (int s = 0; s < axi_pkg::num_slaves; s++) begin
        if (s_done[s]) begin
          s_lock[s] <= 1'b0;
        end else if (s_arvalid[s] && s_arready[s]) begin
          s_lock[s] <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: axi_pkg.sv
`default_nettype none

package axi_pkg;

  // Master-side field widths
  parameter int id_bits = 4;
  parameter int addr_bits = 32;
  parameter int len_bits = 4;
  parameter int size_bits = 3;
  parameter int data_bits = 32;
  parameter int resp_bits = 2;

  // Slave side carries one extra bit for the master index
  parameter int ids_bits = id_bits + 1;

  parameter int num_masters = 2;
  parameter int num_slaves = 4;

  // Address map by upper 16 bits
  parameter int page_lsb = 16;
  parameter logic [addr_bits-page_lsb-1:0] page_s0 = 16'h0000;
  parameter logic [addr_bits-page_lsb-1:0] page_s1 = 16'h0001;
  parameter logic [addr_bits-page_lsb-1:0] page_s2 = 16'h1000;

  typedef enum logic [1:0] {
    burst_fixed = 2'b00,
    burst_incr  = 2'b01,
    burst_wrap  = 2'b10
  } burst_e;

  typedef enum logic [1:0] {
    arb_free = 2'b00,
    arb_m0   = 2'b01,
    arb_m1   = 2'b10
  } arb_state_e;

  typedef logic [num_slaves-1:0] slave_sel_t;

  typedef struct packed {
    logic [id_bits-1:0]   id;
    logic [addr_bits-1:0] addr;
    logic [len_bits-1:0]  len;
    logic [size_bits-1:0] size;
    burst_e               burst;
  } ar_req_t;

  typedef struct packed {
    logic [ids_bits-1:0]  id;
    logic [addr_bits-1:0] addr;
    logic [len_bits-1:0]  len;
    logic [size_bits-1:0] size;
    burst_e               burst;
  } ar_sreq_t;

  typedef struct packed {
    logic [ids_bits-1:0]  id;
    logic [data_bits-1:0] data;
    logic [resp_bits-1:0] resp;
    logic                 last;
  } r_beat_t;

  typedef struct packed {
    logic [id_bits-1:0]   id;
    logic [data_bits-1:0] data;
    logic [resp_bits-1:0] resp;
    logic                 last;
  } r_mbeat_t;

  // Slave 3 takes everything outside the three mapped pages
  function automatic slave_sel_t addr_decode(input logic [addr_bits-1:0] addr);
    slave_sel_t sel;
    case (addr[addr_bits-1:page_lsb])
      page_s0: sel = 4'b0001;
      page_s1: sel = 4'b0010;
      page_s2: sel = 4'b0100;
      default: sel = 4'b1000;
    endcase
    return sel;
  endfunction

endpackage

`default_nettype wire

// File: axi_read_xbar.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_xbar (
  input  wire logic                                          clk,
  input  wire logic                                          rstn,
  // Masters
  input  wire axi_pkg::ar_req_t [axi_pkg::num_masters-1:0]   m_ar,
  input  wire logic [axi_pkg::num_masters-1:0]               m_arvalid,
  output logic [axi_pkg::num_masters-1:0]                    m_arready,
  output axi_pkg::r_mbeat_t [axi_pkg::num_masters-1:0]       m_r,
  output logic [axi_pkg::num_masters-1:0]                    m_rvalid,
  input  wire logic [axi_pkg::num_masters-1:0]               m_rready,
  // Slaves
  output axi_pkg::ar_sreq_t [axi_pkg::num_slaves-1:0]        s_ar,
  output logic [axi_pkg::num_slaves-1:0]                     s_arvalid,
  input  wire logic [axi_pkg::num_slaves-1:0]                s_arready,
  input  wire axi_pkg::r_beat_t [axi_pkg::num_slaves-1:0]    s_r,
  input  wire logic [axi_pkg::num_slaves-1:0]                s_rvalid,
  output logic [axi_pkg::num_slaves-1:0]                     s_rready
);

  axi_pkg::ar_sreq_t               g_ar;
  logic                            g_arvalid;
  logic                            g_arready;
  logic [axi_pkg::num_masters-1:0] m_done;
  logic [axi_pkg::num_slaves-1:0]  s_done;

  ar_arbiter i_ar_arbiter (
    .clk       (clk),
    .rstn      (rstn),
    .m_ar      (m_ar),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .g_ar      (g_ar),
    .g_arvalid (g_arvalid),
    .g_arready (g_arready),
    .m_done    (m_done)
  );

  ar_decoder i_ar_decoder (
    .clk       (clk),
    .rstn      (rstn),
    .g_ar      (g_ar),
    .g_arvalid (g_arvalid),
    .g_arready (g_arready),
    .s_ar      (s_ar),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_done    (s_done)
  );

  r_return_router i_r_return_router (
    .s_r      (s_r),
    .s_rvalid (s_rvalid),
    .s_rready (s_rready),
    .m_r      (m_r),
    .m_rvalid (m_rvalid),
    .m_rready (m_rready),
    .m_done   (m_done),
    .s_done   (s_done)
  );

endmodule

`default_nettype wire

// File: axi_read_xbar_chk.sv
`timescale 1ns/10ps
`default_nettype none

module axi_read_xbar_chk (
  input wire logic                                          clk,
  input wire logic                                          rstn,
  input wire logic [axi_pkg::num_masters-1:0]               m_arvalid,
  input wire logic [axi_pkg::num_masters-1:0]               m_arready,
  input wire axi_pkg::r_mbeat_t [axi_pkg::num_masters-1:0]  m_r,
  input wire logic [axi_pkg::num_masters-1:0]               m_rvalid,
  input wire logic [axi_pkg::num_masters-1:0]               m_rready,
  input wire axi_pkg::ar_sreq_t [axi_pkg::num_slaves-1:0]   s_ar,
  input wire logic [axi_pkg::num_slaves-1:0]                s_arvalid,
  input wire logic [axi_pkg::num_slaves-1:0]                s_arready
);

  // Shadow of the per-master outstanding read
  logic [axi_pkg::num_masters-1:0] locked;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      locked <= '0;
    end else begin
      for (int m = 0; m < axi_pkg::num_masters; m++) begin
        if (m_rvalid[m] && m_rready[m] && m_r[m].last) begin
          locked[m] <= 1'b0;
        end else if (m_arvalid[m] && m_arready[m]) begin
          locked[m] <= 1'b1;
        end
      end
    end
  end

  genvar g;
  for (g = 0; g < axi_pkg::num_masters; g++) begin : g_master
    assert property (@(posedge clk) disable iff (!rstn) locked[g] |-> !m_arready[g])
      else $error("arready high for locked master %0d", g);
  end

  for (g = 0; g < axi_pkg::num_slaves; g++) begin : g_slave
    assert property (@(posedge clk) disable iff (!rstn)
      s_arvalid[g] && !s_arready[g] |=> s_arvalid[g] && $stable(s_ar[g]))
      else $error("slave %0d request changed while waiting", g);
  end

  assert property (@(posedge clk) disable iff (!rstn) $onehot0(s_arvalid))
    else $error("more than one slave arvalid");

endmodule

bind axi_read_xbar axi_read_xbar_chk i_axi_read_xbar_chk (.*);

`default_nettype wire

// File: compile.f
axi_pkg.sv
ar_arbiter.sv
ar_decoder.sv
r_return_router.sv
axi_read_xbar.sv
axi_read_xbar_chk.sv
tb_axi_read_xbar.sv

// File: r_return_router.sv
`timescale 1ns/10ps
`default_nettype none

module r_return_router (
  input  wire axi_pkg::r_beat_t [axi_pkg::num_slaves-1:0]    s_r,
  input  wire logic [axi_pkg::num_slaves-1:0]                s_rvalid,
  output logic [axi_pkg::num_slaves-1:0]                     s_rready,
  output axi_pkg::r_mbeat_t [axi_pkg::num_masters-1:0]       m_r,
  output logic [axi_pkg::num_masters-1:0]                    m_rvalid,
  input  wire logic [axi_pkg::num_masters-1:0]               m_rready,
  output logic [axi_pkg::num_masters-1:0]                    m_done,
  output logic [axi_pkg::num_slaves-1:0]                     s_done
);

  localparam int idx_bit = axi_pkg::ids_bits - 1;

  // At most one slave targets a master at a time, so a plain OR-select is enough
  always_comb begin
    for (int m = 0; m < axi_pkg::num_masters; m++) begin
      m_r[m] = '0;
      m_rvalid[m] = 1'b0;
      for (int s = 0; s < axi_pkg::num_slaves; s++) begin
        if (s_rvalid[s] && s_r[s].id[idx_bit] == 1'(m)) begin
          m_rvalid[m]  = 1'b1;
          m_r[m].id    = s_r[s].id[axi_pkg::id_bits-1:0];
          m_r[m].data  = s_r[s].data;
          m_r[m].resp  = s_r[s].resp;
          m_r[m].last  = s_r[s].last;
        end
      end
    end
  end

  // Ready comes back from the master named in the ID
  always_comb begin
    for (int s = 0; s < axi_pkg::num_slaves; s++) begin
      s_rready[s] = m_rready[s_r[s].id[idx_bit]];
      s_done[s] = s_rvalid[s] && s_rready[s] && s_r[s].last;
    end
  end

  always_comb begin
    for (int m = 0; m < axi_pkg::num_masters; m++) begin
      m_done[m] = m_rvalid[m] && m_rready[m] && m_r[m].last;
    end
  end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Build and run the AXI read crossbar testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_axi_read_xbar \
  -f compile.f \
  -o sim_tb_axi_read_xbar
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/sim_tb_axi_read_xbar
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit $status
fi

exit 0

// File: tb_axi_read_xbar.sv
`timescale 1ns/10ps
`default_nettype none

module tb_axi_read_xbar;

  localparam int wait_limit = 100;

  logic clk;
  logic rstn;

  axi_pkg::ar_req_t [axi_pkg::num_masters-1:0]  m_ar;
  logic [axi_pkg::num_masters-1:0]              m_arvalid;
  logic [axi_pkg::num_masters-1:0]              m_arready;
  axi_pkg::r_mbeat_t [axi_pkg::num_masters-1:0] m_r;
  logic [axi_pkg::num_masters-1:0]              m_rvalid;
  logic [axi_pkg::num_masters-1:0]              m_rready;
  axi_pkg::ar_sreq_t [axi_pkg::num_slaves-1:0]  s_ar;
  logic [axi_pkg::num_slaves-1:0]               s_arvalid;
  logic [axi_pkg::num_slaves-1:0]               s_arready;
  axi_pkg::r_beat_t [axi_pkg::num_slaves-1:0]   s_r;
  logic [axi_pkg::num_slaves-1:0]               s_rvalid;
  logic [axi_pkg::num_slaves-1:0]               s_rready;

  logic [31:0] rng_state;

  axi_read_xbar i_axi_read_xbar (
    .clk       (clk),
    .rstn      (rstn),
    .m_ar      (m_ar),
    .m_arvalid (m_arvalid),
    .m_arready (m_arready),
    .m_r       (m_r),
    .m_rvalid  (m_rvalid),
    .m_rready  (m_rready),
    .s_ar      (s_ar),
    .s_arvalid (s_arvalid),
    .s_arready (s_arready),
    .s_r       (s_r),
    .s_rvalid  (s_rvalid),
    .s_rready  (s_rready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check_sreq(input string name, input axi_pkg::ar_sreq_t got,
                            input axi_pkg::ar_sreq_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_beat(input string name, input axi_pkg::r_mbeat_t got,
                            input axi_pkg::r_mbeat_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      stop_run($sformatf("FAILED %s got %h expected %h", name, got, exp));
    end
  endtask

  function automatic axi_pkg::ar_req_t make_req(input logic [3:0] id, input logic [31:0] addr,
                                                input logic [3:0] len);
    axi_pkg::ar_req_t r;
    r.id    = id;
    r.addr  = addr;
    r.len   = len;
    r.size  = 3'd2;
    r.burst = axi_pkg::burst_incr;
    return r;
  endfunction

  // Slave ID is the master index on top of the master ID
  function automatic axi_pkg::ar_sreq_t to_sreq(input int m, input axi_pkg::ar_req_t r);
    axi_pkg::ar_sreq_t e;
    e.id    = {1'(m), r.id};
    e.addr  = r.addr;
    e.len   = r.len;
    e.size  = r.size;
    e.burst = r.burst;
    return e;
  endfunction

  task automatic issue_req(input int m, input axi_pkg::ar_req_t r);
    int t;
    t = 0;
    m_ar[m] = r;
    m_arvalid[m] = 1'b1;
    #1;
    while (!m_arready[m]) begin
      if (t == wait_limit) stop_run($sformatf("Timeout: master %0d request never accepted", m));
      t++;
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    m_arvalid[m] = 1'b0;
  endtask

  task automatic accept_req(input int s, input axi_pkg::ar_sreq_t exp,
                            output axi_pkg::ar_sreq_t got);
    int t;
    t = 0;
    #1;
    while (!(s_arvalid[s] && s_arready[s])) begin
      if (t == wait_limit) stop_run($sformatf("Timeout: slave %0d never saw a request", s));
      t++;
      @(negedge clk);
      #1;
    end
    got = s_ar[s];
    check_sreq($sformatf("s_ar[%0d]", s), got, exp);
    for (int k = 0; k < axi_pkg::num_slaves; k++) begin
      if (k != s) check_bit($sformatf("s_arvalid[%0d]", k), s_arvalid[k], 1'b0);
    end
  endtask

  // Beat i carries addr + 4*i
  task automatic send_beats(input int s, input axi_pkg::ar_sreq_t req);
    int t;
    for (int i = 0; i <= int'(req.len); i++) begin
      @(negedge clk);
      s_r[s].id   = req.id;
      s_r[s].data = req.addr + 32'(4 * i);
      s_r[s].resp = 2'b00;
      s_r[s].last = (i == int'(req.len));
      s_rvalid[s] = 1'b1;
      t = 0;
      #1;
      while (!s_rready[s]) begin
        if (t == wait_limit) stop_run($sformatf("Timeout: slave %0d beat never taken", s));
        t++;
        @(negedge clk);
        #1;
      end
    end
    @(negedge clk);
    s_rvalid[s] = 1'b0;
    s_r[s] = '0;
  endtask

  task automatic serve_slave(input int s, input axi_pkg::ar_sreq_t exp);
    axi_pkg::ar_sreq_t got;
    accept_req(s, exp, got);
    send_beats(s, got);
  endtask

  task automatic recv_beats(input int m, input axi_pkg::ar_req_t r);
    axi_pkg::r_mbeat_t exp;
    int i;
    int t;
    bit done;
    i = 0;
    t = 0;
    done = 1'b0;
    while (!done) begin
      #1;
      if (m_rvalid[m] && m_rready[m]) begin
        exp.id   = r.id;
        exp.data = r.addr + 32'(4 * i);
        exp.resp = 2'b00;
        exp.last = (i == int'(r.len));
        check_beat($sformatf("m_r[%0d]", m), m_r[m], exp);
        if (i == int'(r.len)) done = 1'b1;
        i++;
        t = 0;
      end else begin
        if (t == wait_limit) stop_run($sformatf("Timeout: master %0d missing read data", m));
        t++;
      end
      if (!done) @(negedge clk);
    end
  endtask

  task automatic read_txn(input int m, input int s, input axi_pkg::ar_req_t r);
    fork
      issue_req(m, r);
      serve_slave(s, to_sreq(m, r));
      recv_beats(m, r);
    join
  endtask

  // Holds a request that must stay blocked for the given number of cycles
  task automatic hold_blocked(input int m, input axi_pkg::ar_req_t r, input int s,
                              input int cycles);
    m_ar[m] = r;
    m_arvalid[m] = 1'b1;
    repeat (cycles) begin
      #1;
      check_bit($sformatf("m_arready[%0d]", m), m_arready[m], 1'b0);
      check_bit($sformatf("s_arvalid[%0d]", s), s_arvalid[s], 1'b0);
      @(negedge clk);
    end
  endtask

  task automatic test_decode();
    logic [31:0] bases [5];
    int slv [5];
    axi_pkg::ar_req_t r;
    bases = '{32'h0000_0000, 32'h0001_0000, 32'h1000_0000, 32'h0002_0000, 32'hF000_0000};
    slv = '{0, 1, 2, 3, 3};
    for (int k = 0; k < 5; k++) begin
      r = make_req(4'(next_random() & 32'hF), bases[k] | (next_random() & 32'hFFFC),
                   4'(next_random() & 32'h3));
      @(negedge clk);
      read_txn(k % 2, slv[k], r);
    end
  endtask

  task automatic test_priority();
    axi_pkg::ar_req_t a;
    axi_pkg::ar_req_t b;
    a = make_req(4'h3, 32'h0000_0100, 4'd1);
    b = make_req(4'h5, 32'h0001_0200, 4'd2);
    @(negedge clk);
    fork
      issue_req(0, a);
      issue_req(1, b);
      serve_slave(0, to_sreq(0, a));
      serve_slave(1, to_sreq(1, b));
      recv_beats(0, a);
      recv_beats(1, b);
      begin
        m_rready[1] = 1'b0;
        #1;
        check_bit("m_arready[1]", m_arready[1], 1'b0);
        check_bit("s_arvalid[0]", s_arvalid[0], 1'b1);
        check_bit("s_arvalid[1]", s_arvalid[1], 1'b0);
        // M1 data stalls while its rready is low
        repeat (3) @(negedge clk);
        #1;
        check_bit("m_rvalid[1]", m_rvalid[1], 1'b1);
        check_bit("s_rready[1]", s_rready[1], 1'b0);
        @(negedge clk);
        m_rready[1] = 1'b1;
      end
    join
  endtask

  task automatic test_backpressure();
    axi_pkg::ar_req_t a;
    axi_pkg::ar_req_t b;
    a = make_req(4'h1, 32'h0000_0040, 4'd0);
    b = make_req(4'h9, 32'h0001_0080, 4'd1);
    s_arready[1] = 1'b0;
    @(negedge clk);
    m_ar[1] = b;
    m_arvalid[1] = 1'b1;
    @(negedge clk);
    m_ar[0] = a;
    m_arvalid[0] = 1'b1;
    repeat (4) begin
      #1;
      check_bit("s_arvalid[1]", s_arvalid[1], 1'b1);
      check_sreq("s_ar[1]", s_ar[1], to_sreq(1, b));
      check_bit("m_arready[0]", m_arready[0], 1'b0);
      check_bit("s_arvalid[0]", s_arvalid[0], 1'b0);
      @(negedge clk);
    end
    s_arready[1] = 1'b1;
    fork
      issue_req(0, a);
      issue_req(1, b);
      serve_slave(0, to_sreq(0, a));
      serve_slave(1, to_sreq(1, b));
      recv_beats(0, a);
      recv_beats(1, b);
    join
  endtask

  // First read busy on slave bs, second request r2 blocked until its last beat
  task automatic busy_then_next(input int m1, input axi_pkg::ar_req_t r1, input int bs,
                                input int m2, input axi_pkg::ar_req_t r2, input int s2,
                                input int blk_slave);
    axi_pkg::ar_sreq_t got;
    @(negedge clk);
    fork
      issue_req(m1, r1);
      accept_req(bs, to_sreq(m1, r1), got);
    join
    fork
      send_beats(bs, got);
      recv_beats(m1, r1);
      hold_blocked(m2, r2, blk_slave, int'(r1.len) + 2);
    join
    read_txn(m2, s2, r2);
  endtask

  task automatic test_master_lock();
    busy_then_next(0, make_req(4'h2, 32'h0000_1000, 4'd3), 0,
                   0, make_req(4'h4, 32'h1000_2000, 4'd1), 2, 2);
  endtask

  task automatic test_slave_lock();
    axi_pkg::ar_req_t a;
    axi_pkg::ar_req_t b;
    a = make_req(4'h6, 32'h0001_0000 | (next_random() & 32'hFFFC),
                 4'(next_random() & 32'hF));
    b = make_req(4'hA, 32'h1000_0000 | (next_random() & 32'hFFFC),
                 4'(next_random() & 32'hF));
    @(negedge clk);
    fork
      read_txn(0, 1, a);
      read_txn(1, 2, b);
    join
    busy_then_next(0, make_req(4'h7, 32'h4000_0000, 4'(next_random() & 32'hF)), 3,
                   1, make_req(4'hB, 32'h5000_0010, 4'(next_random() & 32'h7)), 3, 3);
  endtask

  initial begin
    rng_state = 32'd73842;
    rstn = 1'b0;
    m_ar = '0;
    m_arvalid = '0;
    m_rready = '1;
    s_arready = '1;
    s_r = '0;
    s_rvalid = '0;
    repeat (8) @(negedge clk);
    rstn = 1'b1;
    #1;
    for (int m = 0; m < axi_pkg::num_masters; m++) begin
      check_bit($sformatf("m_arready[%0d]", m), m_arready[m], 1'b0);
      check_bit($sformatf("m_rvalid[%0d]", m), m_rvalid[m], 1'b0);
    end
    for (int s = 0; s < axi_pkg::num_slaves; s++) begin
      check_bit($sformatf("s_arvalid[%0d]", s), s_arvalid[s], 1'b0);
    end
    test_decode();
    test_priority();
    test_backpressure();
    test_master_lock();
    test_slave_lock();
    repeat (2) @(negedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

`default_nettype wire
